// ==== common/core_defines.svh ====
// Word addressing throughout; widths below are tied to the 32-bit instruction layout
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define XLEN      32

// Register file size and index width
`define NUM_REGS  32
`define REG_AW    5

// Instruction field widths
`define IMM_W     17
`define TARGET_W  27

`endif

// ==== common/isa_pkg.sv ====
// Covers only the kept subset; unlisted opcodes and ALU codes decode as no-ops
`default_nettype none

`include "core_defines.svh"

package isa_pkg;

    typedef enum logic [4:0] {
        OP_R    = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] shamt;
        alu_op_e    alu_op;
        logic [1:0] zero;                  // Unused low bits
    } r_fmt_t;

    typedef struct packed {
        opcode_e             opcode;
        logic [4:0]          rd;
        logic [4:0]          rs;
        logic [`IMM_W-1:0]   imm;          // Sign-extended on use
    } i_fmt_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [`TARGET_W-1:0]  target;
    } j_fmt_t;

    // One fetched word, viewed through whichever format the opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
// Pipeline register layouts; every stage qualifies its entry with the valid bit
`default_nettype none

`include "core_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              use_imm;       // ALU B takes the immediate
        logic              is_branch_ne;
        logic              is_branch_lt;
        logic              is_jump;
        isa_pkg::alu_op_e  alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        isa_pkg::instr_u     instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        ctrl_t                 ctrl;
        logic [`REG_AW-1:0]    rd;
        logic [`REG_AW-1:0]    rs;
        logic [`REG_AW-1:0]    rt;        // Port B index, rt or rd
        logic [`XLEN-1:0]      op_a;
        logic [`XLEN-1:0]      op_b;
        logic [`XLEN-1:0]      imm;
        logic [4:0]            shamt;
        logic [`TARGET_W-1:0]  target;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    result;      // ALU value or data address
        logic [`XLEN-1:0]    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                we;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    data;
    } wb_t;

    typedef struct packed {
        logic              taken;
        logic [`XLEN-1:0]  target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/fetch/fetch_stage.sv ====
// PC counts in words from 0; a redirect always beats a load-use stall
`default_nettype none

`include "core_defines.svh"

module fetch_stage (
    input  wire logic                 clock,
    input  wire logic                 rst_n_i,
    input  wire logic                 stall_i,
    input  wire pipe_pkg::redirect_t  redirect_i,
    input  wire logic [`XLEN-1:0]     imem_data_i,
    output logic [`XLEN-1:0]          imem_addr_o,
    output pipe_pkg::if_id_t          if_id_o
);
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] if_pc_q;
    logic [`XLEN-1:0] if_instr_q;
    logic             if_valid_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (!stall_i) begin
            pc_q <= pc_q + 1'b1;               // Next word
        end
    end

    assign imem_addr_o = pc_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_valid_q <= 1'b0;
        end else if (redirect_i.taken) begin
            if_valid_q <= 1'b0;                // Squash wrong-path fetch
        end else if (!stall_i) begin
            if_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall_i) begin
            if_pc_q    <= pc_q;
            if_instr_q <= imem_data_i;
        end
    end

    assign if_id_o = {if_valid_q, if_pc_q, if_instr_q};

    // PC and IF/ID hold for exactly one cycle per load-use stall
    a_stall_one_cycle: assert property (@(posedge clock) disable iff (!rst_n_i)
        stall_i |=> !stall_i);

endmodule

`default_nettype wire

// ==== rtl/decode/reg_file.sv ====
// r0 is hard-wired to zero; a same-cycle write is visible on both read ports
`default_nettype none

`include "core_defines.svh"

module reg_file (
    input  wire logic                clock,
    input  wire logic                rst_n_i,
    input  wire logic                we_i,
    input  wire logic [`REG_AW-1:0]  waddr_i,
    input  wire logic [`XLEN-1:0]    wdata_i,
    input  wire logic [`REG_AW-1:0]  raddr_a_i,
    input  wire logic [`REG_AW-1:0]  raddr_b_i,
    output logic [`XLEN-1:0]         rdata_a_o,
    output logic [`XLEN-1:0]         rdata_b_o
);
    logic [`XLEN-1:0] regs_q [1:`NUM_REGS-1];

    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (we_i && idx == waddr_i) begin
            return wdata_i;                    // Write-through
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

`default_nettype wire

// ==== rtl/decode/decode_stage.sv ====
// Writes to r0 are dropped at issue; the stall covers only a load directly ahead
`default_nettype none

`include "core_defines.svh"

module decode_stage (
    input  wire logic                 clock,
    input  wire logic                 rst_n_i,
    input  wire pipe_pkg::if_id_t     if_id_i,
    input  wire pipe_pkg::wb_t        wb_i,
    input  wire pipe_pkg::redirect_t  redirect_i,
    output logic                      stall_o,
    output pipe_pkg::id_ex_t          id_ex_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_u              instr;
    ctrl_t               ctrl;
    id_ex_t              id_ex_d;
    logic [`REG_AW-1:0]  rb_idx;
    logic [`XLEN-1:0]    rdata_a;
    logic [`XLEN-1:0]    rdata_b;
    logic                use_a;
    logic                use_b;
    logic                load_ahead;

    assign instr = if_id_i.instr;

    // Branches and stores read rd on port B
    assign rb_idx = (instr.r.opcode == OP_R) ? instr.r.rt : instr.r.rd;

    always_comb begin
        ctrl  = '0;
        use_a = 1'b1;
        use_b = 1'b0;
        case (instr.r.opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = instr.r.alu_op;
                use_b          = 1'b1;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                use_b          = 1'b1;         // Store data comes from rd
            end
            OP_BNE: begin
                ctrl.is_branch_ne = 1'b1;
                use_b             = 1'b1;
            end
            OP_BLT: begin
                ctrl.is_branch_lt = 1'b1;
                use_b             = 1'b1;
            end
            OP_J: begin
                ctrl.is_jump = 1'b1;
                use_a        = 1'b0;
            end
            default: begin
                use_a = 1'b0;                  // Treated as a no-op
            end
        endcase
        if (instr.r.rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign load_ahead = id_ex_o.valid && id_ex_o.ctrl.mem_read && (id_ex_o.rd != '0);

    assign stall_o = if_id_i.valid && load_ahead &&
                     ((use_a && instr.r.rs == id_ex_o.rd) ||
                      (use_b && rb_idx == id_ex_o.rd));

    reg_file i_reg_file (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_i.we),
        .waddr_i   (wb_i.rd),
        .wdata_i   (wb_i.data),
        .raddr_a_i (instr.r.rs),
        .raddr_b_i (rb_idx),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    always_comb begin
        id_ex_d.valid  = if_id_i.valid && !stall_o && !redirect_i.taken;
        id_ex_d.pc     = if_id_i.pc;
        id_ex_d.ctrl   = ctrl;
        id_ex_d.rd     = instr.r.rd;
        id_ex_d.rs     = instr.r.rs;
        id_ex_d.rt     = rb_idx;
        id_ex_d.op_a   = rdata_a;
        id_ex_d.op_b   = rdata_b;
        id_ex_d.imm    = {{(`XLEN-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm};
        id_ex_d.shamt  = instr.r.shamt;
        id_ex_d.target = instr.j.target;
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o.valid <= 1'b0;
            id_ex_o.ctrl  <= '0;
        end else begin
            id_ex_o <= id_ex_d;                // Bubble when valid is low
        end
    end

    a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n_i)
        !(wb_i.we && wb_i.rd == '0 && wb_i.data != '0));

endmodule

`default_nettype wire

// ==== rtl/execute/execute_stage.sv ====
// Forwards from EX/MEM then MEM/WB; a load result is never taken from EX/MEM
`default_nettype none

`include "core_defines.svh"

module execute_stage (
    input  wire logic              clock,
    input  wire logic              rst_n_i,
    input  wire pipe_pkg::id_ex_t  id_ex_i,
    input  wire pipe_pkg::wb_t     wb_i,
    output pipe_pkg::redirect_t    redirect_o,
    output pipe_pkg::ex_mem_t      ex_mem_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] jump_target;
    logic             not_equal;
    logic             less_than;

    function automatic logic [`XLEN-1:0] forward(
        input logic [`REG_AW-1:0] idx,
        input logic [`XLEN-1:0]   reg_val
    );
        if (idx != '0 && ex_mem_o.valid && ex_mem_o.reg_write && ex_mem_o.rd == idx) begin
            return ex_mem_o.result;            // Newest producer wins
        end else if (idx != '0 && wb_i.we && wb_i.rd == idx) begin
            return wb_i.data;
        end
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex_i.rs, id_ex_i.op_a);
        fwd_b = forward(id_ex_i.rt, id_ex_i.op_b);
    end

    assign alu_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: alu_res = fwd_a + alu_b;
            ALU_SUB: alu_res = fwd_a - alu_b;
            ALU_AND: alu_res = fwd_a & alu_b;
            ALU_OR:  alu_res = fwd_a | alu_b;
            ALU_SLL: alu_res = fwd_a << id_ex_i.shamt;
            ALU_SRA: alu_res = $signed(fwd_a) >>> id_ex_i.shamt;
            default: alu_res = '0;
        endcase
    end

    // Branches compare rd (port B) against rs (port A)
    assign not_equal = (fwd_b != fwd_a);
    assign less_than = ($signed(fwd_b) < $signed(fwd_a));

    assign branch_target = id_ex_i.pc + id_ex_i.imm + 1'b1;
    assign jump_target   = {{(`XLEN-`TARGET_W){1'b0}}, id_ex_i.target};

    always_comb begin
        redirect_o.taken  = id_ex_i.valid &&
                            (id_ex_i.ctrl.is_jump ||
                             (id_ex_i.ctrl.is_branch_ne && not_equal) ||
                             (id_ex_i.ctrl.is_branch_lt && less_than));
        redirect_o.target = id_ex_i.ctrl.is_jump ? jump_target : branch_target;
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_o.valid     <= 1'b0;
            ex_mem_o.reg_write <= 1'b0;
            ex_mem_o.mem_read  <= 1'b0;
            ex_mem_o.mem_write <= 1'b0;
        end else begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_read   <= id_ex_i.ctrl.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= alu_res;
            ex_mem_o.store_data <= fwd_b;      // Forwarded rd for sw
        end
    end

    // A taken redirect leaves a bubble behind it
    a_redirect_flush: assert property (@(posedge clock) disable iff (!rst_n_i)
        redirect_o.taken |=> !id_ex_i.valid);

endmodule

`default_nettype wire

// ==== rtl/mem_wb_stage.sv ====
// Data memory must return read data in the same cycle; writes land on the next edge
`default_nettype none

`include "core_defines.svh"

module mem_wb_stage (
    input  wire logic               clock,
    input  wire logic               rst_n_i,
    input  wire pipe_pkg::ex_mem_t  ex_mem_i,
    input  wire logic [`XLEN-1:0]   dmem_rdata_i,
    output logic [`XLEN-1:0]        dmem_addr_o,
    output logic [`XLEN-1:0]        dmem_wdata_o,
    output logic                    dmem_we_o,
    output pipe_pkg::wb_t           wb_o
);
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;
    assign dmem_we_o    = ex_mem_i.valid && ex_mem_i.mem_write;    // Bubbles never store

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o.we   <= ex_mem_i.valid && ex_mem_i.reg_write;
            wb_o.rd   <= ex_mem_i.rd;
            wb_o.data <= ex_mem_i.mem_read ? dmem_rdata_i : ex_mem_i.result;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge clock) disable iff (!rst_n_i)
        !(ex_mem_i.mem_read && ex_mem_i.mem_write));

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// Both memory ports read combinationally in the same cycle; no back-pressure is supported
`default_nettype none

`include "core_defines.svh"

module cpu_top (
    input  wire logic              clock,
    input  wire logic              rst_n_i,
    input  wire logic [`XLEN-1:0]  imem_data_i,
    input  wire logic [`XLEN-1:0]  dmem_rdata_i,
    output logic [`XLEN-1:0]       imem_addr_o,
    output logic [`XLEN-1:0]       dmem_addr_o,
    output logic [`XLEN-1:0]       dmem_wdata_o,
    output logic                   dmem_we_o
);
    import pipe_pkg::*;

    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    wb_t        wb;
    redirect_t  redirect;
    logic       stall;

    fetch_stage i_fetch (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .if_id_o     (if_id)
    );

    decode_stage i_decode (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .if_id_i    (if_id),
        .wb_i       (wb),
        .redirect_i (redirect),
        .stall_o    (stall),
        .id_ex_o    (id_ex)
    );

    execute_stage i_execute (
        .clock      (clock),
        .rst_n_i    (rst_n_i),
        .id_ex_i    (id_ex),
        .wb_i       (wb),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    mem_wb_stage i_mem_wb (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .wb_o         (wb)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Reset is held low from time 0 and released on a rising edge after RESET_CYCLES edges
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clock_o,
    output logic rst_n_o
);
    initial begin
        clock_o = 1'b0;
        forever #(PERIOD / 2) clock_o = ~clock_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        rst_n_o <= 1'b1;                       // Release on the rising edge
    end

endmodule

`default_nettype wire

// ==== dv/tb_cpu.sv ====
// Memories hold 256 words each; the golden file is read from dv/ relative to the project root
`default_nettype none

`include "core_defines.svh"

module tb_cpu;
    localparam int ADDR_W       = 8;
    localparam int MEM_WORDS    = 1 << ADDR_W;
    localparam int QUIET_CYCLES = 100;

    logic             clock;
    logic             rst_n;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic [`XLEN-1:0] dmem_rdata;
    logic             dmem_we;

    logic [`XLEN-1:0] imem [0:MEM_WORDS-1];
    logic [`XLEN-1:0] dmem [0:MEM_WORDS-1];
    logic [`XLEN-1:0] exp_addr_q [$];
    logic [`XLEN-1:0] exp_data_q [$];

    int num_words  = 0;
    int num_stores = 0;
    int store_idx  = 0;
    int checks     = 0;
    int errors     = 0;
    bit loaded     = 1'b0;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (10)
    ) i_clock_gen (
        .clock_o (clock),
        .rst_n_o (rst_n)
    );

    cpu_top i_dut (
        .clock        (clock),
        .rst_n_i      (rst_n),
        .imem_data_i  (imem_data),
        .dmem_rdata_i (dmem_rdata),
        .imem_addr_o  (imem_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we)
    );

    // Unwritten data words differ for every address
    function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] addr);
        return ~addr ^ 32'h5a5a_0000;
    endfunction

    // Both ports read in the same cycle
    assign imem_data  = (imem_addr < MEM_WORDS) ? imem[imem_addr[ADDR_W-1:0]] : '0;
    assign dmem_rdata = (dmem_addr < MEM_WORDS) ? dmem[dmem_addr[ADDR_W-1:0]]
                                                : fill_word(dmem_addr);

    always @(posedge clock) begin
        if (dmem_we === 1'b1 && dmem_addr < MEM_WORDS) begin
            dmem[dmem_addr[ADDR_W-1:0]] <= dmem_wdata;
        end
    end

    task automatic check_value(input string what, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_counts();
        $display("Stores seen %0d of %0d, checks %0d, errors %0d",
                 store_idx, num_stores, checks, errors);
    endtask

    task automatic load_golden();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] d;
        logic [8*128-1:0] rest;
        fd = $fopen("dv/cpu_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the golden file dv/cpu_golden.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);       // Comment up to end of line
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%h", d);
                    if (code != 1) begin
                        errors++;
                        $display("Golden file has an I line without a word");
                    end
                    imem[num_words] = d;
                    num_words++;
                end else if (tag == "D") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    if (code != 2) begin
                        errors++;
                        $display("Golden file has a D line without address and data");
                    end
                    dmem[a[ADDR_W-1:0]] = d;
                end else if (tag == "S") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    if (code != 2) begin
                        errors++;
                        $display("Golden file has an S line without address and data");
                    end
                    exp_addr_q.push_back(a);
                    exp_data_q.push_back(d);
                end else begin
                    errors++;
                    $display("Golden file has a line with unknown tag %s", tag);
                end
            end
            $fclose(fd);
            num_stores = exp_addr_q.size();
        end
    endtask

    // Every store is matched in order against the expected list
    always @(posedge clock) begin
        if (dmem_we === 1'b1) begin
            if (rst_n !== 1'b1) begin
                errors++;
                $display("Store seen during reset at time %0t", $time);
            end else if (store_idx >= num_stores) begin
                errors++;
                $display("Extra store at time %0t after the last expected one: addr %h data %h",
                         $time, dmem_addr, dmem_wdata);
            end else begin
                check_value("store address", dmem_addr, exp_addr_q[store_idx]);
                check_value("store data", dmem_wdata, exp_data_q[store_idx]);
                store_idx++;
            end
        end
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;                          // All-zero word is a no-op add
            dmem[i] = fill_word(i);
        end
        load_golden();
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clock);
        check_value("first fetch address", imem_addr, '0);
        wait (store_idx == num_stores);
        repeat (QUIET_CYCLES) @(posedge clock);    // Watch for stray stores
        report_counts();
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (loaded);
        repeat (20 * num_words + 100) @(posedge clock);
        errors++;
        $display("Timeout: the program did not finish, %0d expected stores never happened",
                 num_stores - store_idx);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/fetch/fetch_stage.sv
rtl/decode/reg_file.sv
rtl/decode/decode_stage.sv
rtl/execute/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
dv/tb_clock_gen.sv
dv/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f list.f -o sim_cpu
./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"

// ==== dv/cpu_golden.txt ====
# Columns: I <instruction word> | D <word address> <data word> | S <word address> <data word>
# I words load from address 0 in order, D preloads data memory, S lists stores in program order
D 10 00000007
D 11 00000003
D 12 FFFFFFF0
D 13 0000012C
I 40400010  # lw   r1, 0x10(r0)
I 40800011  # lw   r2, 0x11(r0)
I 40C00012  # lw   r3, 0x12(r0)
I 01022000  # add  r4, r1, r2
I 01482004  # sub  r5, r4, r2
I 39000020  # sw   r4, 0x20(r0)
I 39400021  # sw   r5, 0x21(r0)
I 01822008  # and  r6, r1, r2
I 39800022  # sw   r6, 0x22(r0)
I 01C2300C  # or   r7, r1, r3
I 39C00023  # sw   r7, 0x23(r0)
I 02020210  # sll  r8, r1, 4
I 02460114  # sra  r9, r3, 2
I 3A000024  # sw   r8, 0x24(r0)
I 3A400025  # sw   r9, 0x25(r0)
I 2A85FFFB  # addi r10, r2, -5
I 2A940064  # addi r10, r10, 100
I 3A800026  # sw   r10, 0x26(r0)
I 42C00013  # lw   r11, 0x13(r0)
I 03161000  # add  r12, r11, r1 after a load-use stall
I 3B000027  # sw   r12, 0x27(r0)
I 10440001  # bne  r1, r2, +1 taken
I 38400030  # sw   r1, 0x30(r0) skipped
I 10420001  # bne  r1, r1, +1 not taken
I 38800028  # sw   r2, 0x28(r0)
I 30C20001  # blt  r3, r1, +1 taken with negative r3
I 38C00031  # sw   r3, 0x31(r0) skipped
I 30460001  # blt  r1, r3, +1 not taken
I 38400029  # sw   r1, 0x29(r0)
I 08000020  # j    32
I 38400032  # sw   r1, 0x32(r0) skipped
I 38800033  # sw   r2, 0x33(r0) skipped
I 39C0002A  # sw   r7, 0x2A(r0)
I 08000021  # j    33 to itself
S 20 0000000A
S 21 00000007
S 22 00000003
S 23 FFFFFFF7
S 24 00000070
S 25 FFFFFFFC
S 26 00000062
S 27 00000133
S 28 00000003
S 29 00000007
S 2A FFFFFFF7
